//--- u2_ctrl_top.f
+incdir+.
hw/u2_ctrl_pkg.sv
hw/setting_reg.sv
hw/control_regs.sv
hw/vita_time.sv
hw/status_readback.sv
hw/u2_ctrl_top.sv
verification/tb_u2_ctrl_top.sv

//--- Makefile
# Verilator build and run of the control plane testbench

OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f u2_ctrl_top.f \
		--top-module tb_u2_ctrl_top -Mdir $(OBJ_DIR) -o sim
	./$(OBJ_DIR)/sim

clean:
	rm -rf $(OBJ_DIR)

//--- verification/tb_u2_ctrl_top.sv
/* Testbench for the motherboard control plane
   Checks settings registers, LED mux, VITA time loads and readback */

`timescale 1ns/1ps
`default_nettype none

`include "u2_ctrl_config.svh"

module tb_u2_ctrl_top
   import u2_ctrl_pkg::*;
();

   localparam int unsigned tb_ticks_per_sec = 100;
   localparam int unsigned watchdog_cycles  = 30000;

   logic         dsp_clk;
   logic         wb_rst;
   logic         set_stb;
   set_addr_t    set_addr;
   set_data_t    set_data;
   logic         pps;
   logic         clk_status;
   logic         link_up;
   logic         sim_mode;
   logic [3:0]   clock_divider;
   logic         rb_stb;
   rb_addr_t     rb_addr;
   clock_ctrl_t  clock_ctrl;
   serdes_ctrl_t serdes_ctrl;
   adc_ctrl_t    adc_ctrl;
   logic         phy_resetn;
   led_t         leds;
   time64_t      time_now;
   rb_data_t     rb_data;
   logic         rb_ack;

   // Expected state of the settings registers and the time counter
   clock_ctrl_t  exp_clock;
   serdes_ctrl_t exp_serdes;
   adc_ctrl_t    exp_adc;
   logic         exp_phy_reset;
   led_t         exp_led_sw;
   led_t         exp_led_src;
   time64_t      exp_time;
   logic [31:0]  lcg_state;

   u2_ctrl_top #(
      .ticks_per_sec (tb_ticks_per_sec)
   ) u_dut (
      .dsp_clk          (dsp_clk),
      .wb_rst           (wb_rst),
      .set_stb_i        (set_stb),
      .set_addr_i       (set_addr),
      .set_data_i       (set_data),
      .pps_i            (pps),
      .clk_status_i     (clk_status),
      .serdes_link_up_i (link_up),
      .sim_mode_i       (sim_mode),
      .clock_divider_i  (clock_divider),
      .rb_stb_i         (rb_stb),
      .rb_addr_i        (rb_addr),
      .clock_ctrl_o     (clock_ctrl),
      .serdes_ctrl_o    (serdes_ctrl),
      .adc_ctrl_o       (adc_ctrl),
      .phy_resetn_o     (phy_resetn),
      .leds_o           (leds),
      .time_o           (time_now),
      .rb_data_o        (rb_data),
      .rb_ack_o         (rb_ack)
   );

   ////////////////////////////////////////////////////////////
   // Reference functions

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic clock_ctrl_t clock_map(set_data_t d);
      clock_ctrl_t c;
      c.ready = d[4];
      c.en    = d[3:2];
      c.sel   = d[1:0];
      return c;
   endfunction

   function automatic serdes_ctrl_t serdes_map(set_data_t d);
      serdes_ctrl_t s;
      s.enable = d[3];
      s.prbsen = d[2];
      s.loopen = d[1];
      s.rx_en  = d[0];
      return s;
   endfunction

   function automatic adc_ctrl_t adc_map(set_data_t d);
      adc_ctrl_t a;
      a.oe_a = d[3];
      a.on_a = d[2];
      a.oe_b = d[1];
      a.on_b = d[0];
      return a;
   endfunction

   // Hardware status sits in the two low LED bits
   function automatic led_t led_mux(led_t src, led_t sw, logic clk_ok, logic link);
      led_t hw;
      led_t l;
      hw    = '0;
      hw[1] = clk_ok;
      hw[0] = link;
      for (int i = 0; i < 8; i++) begin
         l[i] = src[i] ? hw[i] : sw[i];
      end
      return l;
   endfunction

   function automatic time64_t time_advance(time64_t t, int unsigned n);
      time64_t     r;
      logic [31:0] sum;
      sum     = t.ticks + n;
      r.secs  = t.secs + sum / tb_ticks_per_sec;
      r.ticks = sum % tb_ticks_per_sec;
      return r;
   endfunction

   function automatic rb_data_t mode_word(logic sim, logic [3:0] div);
      rb_data_t w;
      w      = '0;
      w[31]  = sim;
      w[3:0] = div;
      return w;
   endfunction

   // Control addresses mixed with unused ones, time words left out
   function automatic set_addr_t pick_addr(logic [31:0] r);
      set_addr_t a;
      case (r[2:0])
         3'd0:    a = 8'(`SR_CLK);
         3'd1:    a = 8'(`SR_SER);
         3'd2:    a = 8'(`SR_ADC);
         3'd3:    a = 8'(`SR_PHY);
         3'd4:    a = 8'd5;
         3'd5:    a = 8'd7;
         3'd6:    a = 8'd100;
         default: a = 8'd255;
      endcase
      return a;
   endfunction

   ////////////////////////////////////////////////////////////
   // Compare tasks

   task automatic fail_run(string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_clock(string name, clock_ctrl_t exp, clock_ctrl_t act);
      if (act !== exp) begin
         fail_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
      end
   endtask

   task automatic check_serdes(string name, serdes_ctrl_t exp, serdes_ctrl_t act);
      if (act !== exp) begin
         fail_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
      end
   endtask

   task automatic check_adc(string name, adc_ctrl_t exp, adc_ctrl_t act);
      if (act !== exp) begin
         fail_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
      end
   endtask

   task automatic check_led(string name, led_t exp, led_t act);
      if (act !== exp) begin
         fail_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
      end
   endtask

   task automatic check_time(string name, time64_t exp, time64_t act);
      if (act !== exp) begin
         fail_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
      end
   endtask

   task automatic check_rb(string name, rb_data_t exp, rb_data_t act);
      if (act !== exp) begin
         fail_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
      end
   endtask

   task automatic check_bit(string name, logic exp, logic act);
      if (act !== exp) begin
         fail_run($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Clock, watchdog and register checker

   initial begin
      dsp_clk = 1'b0;
      forever #10 dsp_clk = ~dsp_clk;
   end

   initial begin
      repeat (watchdog_cycles) @(posedge dsp_clk);
      fail_run("watchdog expired before the tests finished");
   end

   // Outputs are compared before the edge, then the model takes the write
   always @(posedge dsp_clk) begin
      if (wb_rst) begin
         exp_clock     = '0;
         exp_serdes    = '0;
         exp_adc       = '0;
         exp_phy_reset = 1'b0;
         exp_led_sw    = '0;
         exp_led_src   = '0;
      end else begin
         check_clock("clock_ctrl", exp_clock, clock_ctrl);
         check_serdes("serdes_ctrl", exp_serdes, serdes_ctrl);
         check_adc("adc_ctrl", exp_adc, adc_ctrl);
         check_bit("phy_resetn", ~exp_phy_reset, phy_resetn);
         check_led("leds", led_mux(exp_led_src, exp_led_sw, clk_status, link_up), leds);
         if (set_stb) begin
            case (set_addr)
               8'(`SR_CLK):     exp_clock     = clock_map(set_data);
               8'(`SR_SER):     exp_serdes    = serdes_map(set_data);
               8'(`SR_ADC):     exp_adc       = adc_map(set_data);
               8'(`SR_PHY):     exp_phy_reset = set_data[0];
               8'(`SR_LED):     exp_led_sw    = set_data[7:0];
               8'(`SR_LED_SRC): exp_led_src   = set_data[7:0];
               default: ;
            endcase
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Stimulus helpers, all aligned to the falling edge

   task automatic next_cycle();
      @(negedge dsp_clk);
      exp_time = time_advance(exp_time, 1);
   endtask

   task automatic write_setting(set_addr_t addr, set_data_t data);
      set_stb  = 1'b1;
      set_addr = addr;
      set_data = data;
      next_cycle();
      set_stb  = 1'b0;
   endtask

   task automatic read_word(rb_addr_t addr, output rb_data_t data);
      rb_stb  = 1'b1;
      rb_addr = addr;
      next_cycle();
      rb_stb  = 1'b0;
      check_bit("rb_ack", 1'b1, rb_ack);
      data = rb_data;
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence

   initial begin
      time64_t     load_val;
      time64_t     snap;
      rb_data_t    rd_a;
      rb_data_t    rd_b;
      set_addr_t   a;
      set_data_t   d;
      logic [31:0] r;
      int unsigned gap;

      lcg_state     = 32'h6deaacdb;
      wb_rst        = 1'b1;
      set_stb       = 1'b0;
      set_addr      = '0;
      set_data      = '0;
      pps           = 1'b0;
      clk_status    = 1'b0;
      link_up       = 1'b0;
      sim_mode      = 1'b0;
      clock_divider = '0;
      rb_stb        = 1'b0;
      rb_addr       = '0;
      exp_time      = '0;

      // Reset values
      repeat (2) @(negedge dsp_clk);
      wb_rst   = 1'b0;
      exp_time = '0;
      check_clock("reset clock_ctrl", '0, clock_ctrl);
      check_serdes("reset serdes_ctrl", '0, serdes_ctrl);
      check_adc("reset adc_ctrl", '0, adc_ctrl);
      check_led("reset leds", '0, leds);
      check_bit("reset phy_resetn", 1'b1, phy_resetn);
      check_bit("reset rb_ack", 1'b0, rb_ack);
      check_time("reset time", exp_time, time_now);

      // Settings writes, checked every cycle by the register checker
      for (int i = 0; i < 40; i++) begin
         a = pick_addr(next_rand());
         d = next_rand();
         write_setting(a, d);
      end
      next_cycle();

      // LED mux with changing status inputs
      for (int i = 0; i < 30; i++) begin
         r          = next_rand();
         d          = next_rand();
         clk_status = r[0];
         link_up    = r[1];
         case (r[3:2])
            2'd0:    write_setting(8'(`SR_LED), d);
            2'd1:    write_setting(8'(`SR_LED_SRC), d);
            default: next_cycle();
         endcase
      end
      next_cycle();

      // Immediate load close to a seconds boundary
      load_val.secs  = next_rand();
      load_val.ticks = 32'd95;
      write_setting(8'(`SR_TIME64), load_val.secs);
      write_setting(8'(`SR_TIME64 + 1), load_val.ticks);
      write_setting(8'(`SR_TIME64 + 2), 32'd1);
      check_time("count before load", exp_time, time_now);
      next_cycle();
      check_time("count while arming", exp_time, time_now);
      next_cycle();
      exp_time = load_val;
      check_time("immediate load", exp_time, time_now);
      for (int i = 0; i < 20; i++) begin
         next_cycle();
         check_time("count after load", exp_time, time_now);
      end

      // PPS armed load
      load_val.secs  = next_rand();
      load_val.ticks = next_rand() % 32'd100;
      write_setting(8'(`SR_TIME64), load_val.secs);
      write_setting(8'(`SR_TIME64 + 1), load_val.ticks);
      write_setting(8'(`SR_TIME64 + 2), 32'd0);
      for (int i = 0; i < 10; i++) begin
         next_cycle();
         check_time("armed without pps", exp_time, time_now);
      end
      pps = 1'b1;
      next_cycle();
      check_time("pps sampled", exp_time, time_now);
      next_cycle();
      check_time("pps edge found", exp_time, time_now);
      next_cycle();
      exp_time = load_val;
      check_time("pps load", exp_time, time_now);
      repeat (3) next_cycle();
      pps = 1'b0;
      repeat (4) next_cycle();
      // A second edge after the load must not reload
      pps = 1'b1;
      for (int i = 0; i < 6; i++) begin
         next_cycle();
         check_time("pps after load", exp_time, time_now);
      end
      pps = 1'b0;

      // Readback of time, mode and unused words
      snap = exp_time;
      read_word(4'(`RB_SECS), rd_a);
      check_rb("rb seconds", snap.secs, rd_a);
      snap = exp_time;
      read_word(4'(`RB_TICKS), rd_a);
      check_rb("rb ticks", snap.ticks, rd_a);
      next_cycle();
      check_bit("rb_ack idle", 1'b0, rb_ack);
      check_rb("rb_data idle", '0, rb_data);
      r             = next_rand();
      sim_mode      = r[4];
      clock_divider = r[3:0];
      read_word(4'(`RB_MODE), rd_a);
      check_rb("rb mode", mode_word(sim_mode, clock_divider), rd_a);
      for (int w = 2; w < 15; w++) begin
         if (w != `RB_MODE) begin
            read_word(4'(w), rd_a);
            check_rb("rb unused word", '0, rd_a);
         end
      end

      // Cycle counter over a random gap
      gap = 3 + (next_rand() % 32'd40);
      read_word(4'(`RB_CYCLES), rd_a);
      repeat (gap - 1) next_cycle();
      read_word(4'(`RB_CYCLES), rd_b);
      check_rb("rb cycle gap", rd_a + gap, rd_b);

      next_cycle();
      $display("Test completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

//--- hw/u2_ctrl_top.sv
/* Motherboard control plane top level
   Settings registers, VITA time and status readback on dsp_clk */

`timescale 1ns/1ps
`default_nettype none

`include "u2_ctrl_config.svh"

module u2_ctrl_top
   import u2_ctrl_pkg::*;
#(
   parameter int unsigned ticks_per_sec = `TICKS_PER_SEC
) (
   input  wire logic       dsp_clk,
   input  wire logic       wb_rst,

   // Settings bus
   input  wire logic       set_stb_i,
   input  wire set_addr_t  set_addr_i,
   input  wire set_data_t  set_data_i,

   // Board status
   input  wire logic       pps_i,
   input  wire logic       clk_status_i,
   input  wire logic       serdes_link_up_i,
   input  wire logic       sim_mode_i,
   input  wire logic [3:0] clock_divider_i,

   // Readback
   input  wire logic       rb_stb_i,
   input  wire rb_addr_t   rb_addr_i,

   // Board control
   output clock_ctrl_t     clock_ctrl_o,
   output serdes_ctrl_t    serdes_ctrl_o,
   output adc_ctrl_t       adc_ctrl_o,
   output logic            phy_resetn_o,
   output led_t            leds_o,

   output time64_t         time_o,
   output rb_data_t        rb_data_o,
   output logic            rb_ack_o
);

   control_regs u_control_regs (
      .clk_i            (dsp_clk),
      .rst_i            (wb_rst),
      .set_stb_i        (set_stb_i),
      .set_addr_i       (set_addr_i),
      .set_data_i       (set_data_i),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .clock_ctrl_o     (clock_ctrl_o),
      .serdes_ctrl_o    (serdes_ctrl_o),
      .adc_ctrl_o       (adc_ctrl_o),
      .phy_resetn_o     (phy_resetn_o),
      .leds_o           (leds_o)
   );

   vita_time #(
      .ticks_per_sec (ticks_per_sec)
   ) u_vita_time (
      .clk_i      (dsp_clk),
      .rst_i      (wb_rst),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .pps_i      (pps_i),
      .time_o     (time_o)
   );

   // Readback sees the same time as the output port
   status_readback u_status_readback (
      .clk_i           (dsp_clk),
      .rst_i           (wb_rst),
      .rb_stb_i        (rb_stb_i),
      .rb_addr_i       (rb_addr_i),
      .time_i          (time_o),
      .sim_mode_i      (sim_mode_i),
      .clock_divider_i (clock_divider_i),
      .rb_data_o       (rb_data_o),
      .rb_ack_o        (rb_ack_o)
   );

endmodule

`default_nettype wire

//--- hw/status_readback.sv
/* Status readback port
   Returns time, mode word and cycle count one cycle after a strobe */

`timescale 1ns/1ps
`default_nettype none

`include "u2_ctrl_config.svh"

module status_readback
   import u2_ctrl_pkg::*;
(
   input  wire logic       clk_i,
   input  wire logic       rst_i,
   input  wire logic       rb_stb_i,
   input  wire rb_addr_t   rb_addr_i,
   input  wire time64_t    time_i,
   input  wire logic       sim_mode_i,
   input  wire logic [3:0] clock_divider_i,
   output rb_data_t        rb_data_o,
   output logic            rb_ack_o
);

   logic [31:0] cycle_cnt;
   rb_data_t    rb_word;

   // Free-running cycle counter
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         cycle_cnt <= '0;
      end else begin
         cycle_cnt <= cycle_cnt + 32'd1;
      end
   end

   ////////////////////////////////////////////////////////////
   // Word select

   always_comb begin
      case (rb_addr_i)
         rb_addr_t'(`RB_SECS):   rb_word = time_i.secs;
         rb_addr_t'(`RB_TICKS):  rb_word = time_i.ticks;
         rb_addr_t'(`RB_MODE):   rb_word = {sim_mode_i, 27'b0, clock_divider_i};
         rb_addr_t'(`RB_CYCLES): rb_word = cycle_cnt;
         default:                rb_word = '0;
      endcase
   end

   // Data is zero whenever no acknowledge is pending
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rb_ack_o  <= 1'b0;
         rb_data_o <= '0;
      end else begin
         rb_ack_o  <= rb_stb_i;
         rb_data_o <= rb_stb_i ? rb_word : '0;
      end
   end

   // Back-to-back acks need a strobe behind each one
   a_ack_needs_stb: assert property (@(posedge clk_i) disable iff (rst_i)
      (rb_ack_o && $past(rb_ack_o)) |-> ($past(rb_stb_i) && $past(rb_stb_i, 2)));

endmodule

`default_nettype wire

//--- hw/vita_time.sv
/* VITA 64-bit time counter
   Seconds and ticks, loaded at once or on the next PPS rising edge */

`timescale 1ns/1ps
`default_nettype none

`include "u2_ctrl_config.svh"

module vita_time
   import u2_ctrl_pkg::*;
#(
   parameter int unsigned ticks_per_sec = `TICKS_PER_SEC
) (
   input  wire logic      clk_i,
   input  wire logic      rst_i,
   input  wire logic      set_stb_i,
   input  wire set_addr_t set_addr_i,
   input  wire set_data_t set_data_i,
   input  wire logic      pps_i,
   output time64_t        time_o
);

   localparam logic [31:0] last_tick = 32'(ticks_per_sec - 1);

   logic [31:0] secs_q;
   logic [31:0] ticks_q;
   logic        mode_imm;
   logic        mode_wr;
   logic [2:0]  pps_sr;
   logic        pps_rise;
   logic        armed;
   logic        load_now;

   ////////////////////////////////////////////////////////////
   // Time settings, three consecutive words

   setting_reg #(
      .my_addr   (set_addr_t'(`SR_TIME64)),
      .payload_t (logic [31:0])
   ) u_sr_secs (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .out_o      (secs_q),
      .changed_o  ()
   );

   setting_reg #(
      .my_addr   (set_addr_t'(`SR_TIME64 + 1)),
      .payload_t (logic [31:0])
   ) u_sr_ticks (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .out_o      (ticks_q),
      .changed_o  ()
   );

   // Writing the mode word arms the load
   setting_reg #(
      .my_addr   (set_addr_t'(`SR_TIME64 + 2)),
      .payload_t (logic)
   ) u_sr_mode (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .out_o      (mode_imm),
      .changed_o  (mode_wr)
   );

   ////////////////////////////////////////////////////////////
   // PPS synchronizer and rising edge

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         pps_sr <= '0;
      end else begin
         pps_sr <= {pps_sr[1:0], pps_i};
      end
   end

   assign pps_rise = pps_sr[1] & ~pps_sr[2];
   assign load_now = armed & (mode_imm | pps_rise);

   // A new mode write re-arms even in the load cycle
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         armed <= 1'b0;
      end else if (mode_wr) begin
         armed <= 1'b1;
      end else if (load_now) begin
         armed <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////
   // Counter

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         time_o <= '0;
      end else if (load_now) begin
         time_o <= {secs_q, ticks_q};
      end else if (time_o.ticks == last_tick) begin
         time_o.ticks <= '0;
         time_o.secs  <= time_o.secs + 32'd1;
      end else begin
         time_o.ticks <= time_o.ticks + 32'd1;
      end
   end

   // Ticks stay below the rate, loaded values included
   a_ticks_range: assert property (@(posedge clk_i) disable iff (rst_i)
      time_o.ticks <= last_tick);

endmodule

`default_nettype wire

//--- hw/control_regs.sv
/* Board control registers
   Clock generator, SERDES, ADC and PHY reset lines plus the LED source mux */

`timescale 1ns/1ps
`default_nettype none

`include "u2_ctrl_config.svh"

module control_regs
   import u2_ctrl_pkg::*;
(
   input  wire logic      clk_i,
   input  wire logic      rst_i,
   input  wire logic      set_stb_i,
   input  wire set_addr_t set_addr_i,
   input  wire set_data_t set_data_i,
   input  wire logic      clk_status_i,
   input  wire logic      serdes_link_up_i,
   output clock_ctrl_t    clock_ctrl_o,
   output serdes_ctrl_t   serdes_ctrl_o,
   output adc_ctrl_t      adc_ctrl_o,
   output logic           phy_resetn_o,
   output led_t           leds_o
);

   logic phy_reset;
   led_t led_sw;
   led_t led_src;
   led_t led_hw;

   ////////////////////////////////////////////////////////////
   // Control line registers

   setting_reg #(
      .my_addr   (set_addr_t'(`SR_CLK)),
      .payload_t (clock_ctrl_t)
   ) u_sr_clk (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .out_o      (clock_ctrl_o),
      .changed_o  ()
   );

   setting_reg #(
      .my_addr   (set_addr_t'(`SR_SER)),
      .payload_t (serdes_ctrl_t)
   ) u_sr_ser (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .out_o      (serdes_ctrl_o),
      .changed_o  ()
   );

   setting_reg #(
      .my_addr   (set_addr_t'(`SR_ADC)),
      .payload_t (adc_ctrl_t)
   ) u_sr_adc (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .out_o      (adc_ctrl_o),
      .changed_o  ()
   );

   // PHY held in reset while bit 0 is set
   setting_reg #(
      .my_addr   (set_addr_t'(`SR_PHY)),
      .payload_t (logic)
   ) u_sr_phy (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .out_o      (phy_reset),
      .changed_o  ()
   );

   assign phy_resetn_o = ~phy_reset;

   ////////////////////////////////////////////////////////////
   // LEDs, source bit 1 selects hardware status

   setting_reg #(
      .my_addr   (set_addr_t'(`SR_LED)),
      .payload_t (led_t)
   ) u_sr_led (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .out_o      (led_sw),
      .changed_o  ()
   );

   setting_reg #(
      .my_addr   (set_addr_t'(`SR_LED_SRC)),
      .payload_t (led_t)
   ) u_sr_led_src (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .out_o      (led_src),
      .changed_o  ()
   );

   assign led_hw = {6'b0, clk_status_i, serdes_link_up_i};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

`default_nettype wire

//--- hw/setting_reg.sv
/* Single settings bus register
   Latches the low bits of a write to its address and pulses changed */

`timescale 1ns/1ps
`default_nettype none

module setting_reg
   import u2_ctrl_pkg::*;
#(
   parameter set_addr_t my_addr = '0,
   parameter type payload_t = logic [31:0]
) (
   input  wire logic      clk_i,
   input  wire logic      rst_i,
   input  wire logic      set_stb_i,
   input  wire set_addr_t set_addr_i,
   input  wire set_data_t set_data_i,
   output payload_t       out_o,
   output logic           changed_o
);

   logic hit;

   assign hit = set_stb_i && (set_addr_i == my_addr);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         out_o     <= payload_t'('0);
         changed_o <= 1'b0;
      end else begin
         changed_o <= hit;
         if (hit) begin
            out_o <= payload_t'(set_data_i[$bits(payload_t)-1:0]);
         end
      end
   end

   // Every changed pulse traces back to a write of this address
   a_changed_src: assert property (@(posedge clk_i) disable iff (rst_i)
      changed_o |-> $past(set_stb_i && (set_addr_i == my_addr)));

endmodule

`default_nettype wire

//--- hw/u2_ctrl_pkg.sv
/* Shared types of the control plane
   Settings bus words, board control words, LED and VITA time formats */

`default_nettype none

package u2_ctrl_pkg;

   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;

   // Clock generator lines, from data bits 4..0
   typedef struct packed {
      logic       ready;
      logic [1:0] en;
      logic [1:0] sel;
   } clock_ctrl_t;

   typedef struct packed {
      logic enable;
      logic prbsen;
      logic loopen;
      logic rx_en;
   } serdes_ctrl_t;

   typedef struct packed {
      logic oe_a;
      logic on_a;
      logic oe_b;
      logic on_b;
   } adc_ctrl_t;

   typedef logic [7:0] led_t;

   // Seconds in the upper word, ticks in the lower
   typedef struct packed {
      logic [31:0] secs;
      logic [31:0] ticks;
   } time64_t;

   typedef logic [3:0]  rb_addr_t;
   typedef logic [31:0] rb_data_t;

endpackage

`default_nettype wire

//--- u2_ctrl_config.svh
/* Control plane configuration for the motherboard core
   Settings bus addresses, readback word indices and the default tick rate */

`ifndef U2_CTRL_CONFIG_SVH
`define U2_CTRL_CONFIG_SVH

// Board control registers on the settings bus
`define SR_CLK      0
`define SR_SER      1
`define SR_ADC      2
`define SR_LED      3
`define SR_PHY      4
`define SR_LED_SRC  8

// VITA time block, three words from the base
// Base+0 seconds, base+1 ticks, base+2 arms the load (bit 0 = immediate)
`define SR_TIME64   192

// Readback word indices
`define RB_SECS     0
`define RB_TICKS    1
`define RB_MODE     9
`define RB_CYCLES   15

// Tick rate of dsp_clk
`define TICKS_PER_SEC 100000000

`endif
